//--- design/issue_slot_if.sv
// issue slot bundle: one slot's micro-op, register indices, pc, exception and immediate
`timescale 1ns/10ps
`default_nettype none

interface issue_slot_if
    import rf_pkg::*;
();

    logic                  en;
    uop_t                  uop;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rj;
    logic [reg_addr_w-1:0] rk;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       pc_next;
    logic [exp_w-1:0]      exp;
    logic [xlen-1:0]       imm;

    modport issue (output en, uop, rd, rj, rk, pc, pc_next, exp, imm);

    modport stage (input en, uop, rd, rj, rk, pc, pc_next, exp, imm);

endinterface

`default_nettype wire

//--- design/operand_select.sv
// operand select: picks a slot's two source operands from the register file, pc, imm or counter
`timescale 1ns/10ps
`default_nettype none

module operand_select
    import rf_pkg::*;
(
    input  wire uop_t            uop,
    input  wire logic [xlen-1:0] rf_a,
    input  wire logic [xlen-1:0] rf_b,
    input  wire logic [xlen-1:0] pc,
    input  wire logic [xlen-1:0] imm,
    input  wire logic [63:0]     count,
    output logic      [xlen-1:0] src_a,
    output logic      [xlen-1:0] src_b
);

    always_comb begin
        src_a = rf_a;
        src_b = rf_b;
        // source fields only mean something for alu uops
        if (uop.itype == itype_alu) begin
            case (uop.src1)
                src1_rf:    src_a = rf_a;
                src1_pc:    src_a = pc;
                src1_zero:  src_a = '0;
                // no counter id yet
                src1_cntid: src_a = '0;
                default:    src_a = rf_a;
            endcase
            case (uop.src2)
                src2_rf:   src_b = rf_b;
                src2_imm:  src_b = imm;
                src2_cntl: src_b = count[31:0];
                src2_cnth: src_b = count[63:32];
                default:   src_b = rf_b;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/reg_array.sv
// register array: 32 words, two write ports, four forwarding read ports, r0 hardwired to zero
`timescale 1ns/10ps
`default_nettype none

module reg_array
    import rf_pkg::*;
(
    input  wire logic                       clk,

    input  wire logic                       wb0_en,
    input  wire logic [reg_addr_w-1:0]      wb0_addr,
    input  wire logic [xlen-1:0]            wb0_data,
    input  wire logic                       wb1_en,
    input  wire logic [reg_addr_w-1:0]      wb1_addr,
    input  wire logic [xlen-1:0]            wb1_data,

    input  wire logic [3:0][reg_addr_w-1:0] raddr,
    output logic      [3:0][xlen-1:0]       rdata
);

    logic [xlen-1:0] mem [reg_count];

    // port 1 is the younger write, so it goes last and wins on a clash
    always_ff @(posedge clk) begin
        if (wb0_en && wb0_addr != '0) begin
            mem[wb0_addr] <= wb0_data;
        end
        if (wb1_en && wb1_addr != '0) begin
            mem[wb1_addr] <= wb1_data;
        end
    end

    // same-cycle writes are forwarded, port 1 first
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (raddr[i] == '0) begin
                rdata[i] = '0;
            end else if (wb1_en && wb1_addr == raddr[i]) begin
                rdata[i] = wb1_data;
            end else if (wb0_en && wb0_addr == raddr[i]) begin
                rdata[i] = wb0_data;
            end else begin
                rdata[i] = mem[raddr[i]];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/rf_pkg.sv
// register-read stage package: data widths, micro-op encodings and micro-op layout
`default_nettype none

package rf_pkg;

    localparam int xlen       = 32;
    localparam int reg_count  = 32;
    localparam int reg_addr_w = 5;
    localparam int exp_w      = 7;

    // instruction class of a micro-op
    typedef enum logic [2:0] {
        itype_alu  = 3'd0,
        itype_mem  = 3'd1,
        itype_br   = 3'd2,
        itype_misc = 3'd3
    } itype_e;

    // first operand source, only honoured for alu uops
    typedef enum logic [1:0] {
        src1_rf    = 2'd0,
        src1_pc    = 2'd1,
        src1_zero  = 2'd2,
        src1_cntid = 2'd3
    } src1_e;

    // second operand source
    typedef enum logic [1:0] {
        src2_rf   = 2'd0,
        src2_imm  = 2'd1,
        src2_cntl = 2'd2,
        src2_cnth = 2'd3
    } src2_e;

    // 15-bit micro-op, op is decoded further down the pipe
    typedef struct packed {
        itype_e     itype;
        src1_e      src1;
        src2_e      src2;
        logic [7:0] op;
    } uop_t;

endpackage

`default_nettype wire

//--- design/rf_read_top.sv
// register-read top: bundles both issue slots and joins the stage with the stable counter
`timescale 1ns/10ps
`default_nettype none

module rf_read_top
    import rf_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  stall,

    input  wire logic                  wb0_en,
    input  wire logic [reg_addr_w-1:0] wb0_addr,
    input  wire logic [xlen-1:0]       wb0_data,
    input  wire logic                  wb1_en,
    input  wire logic [reg_addr_w-1:0] wb1_addr,
    input  wire logic [xlen-1:0]       wb1_data,

    input  wire logic                  s0_en,
    input  wire uop_t                  s0_uop,
    input  wire logic [reg_addr_w-1:0] s0_rd,
    input  wire logic [reg_addr_w-1:0] s0_rj,
    input  wire logic [reg_addr_w-1:0] s0_rk,
    input  wire logic [xlen-1:0]       s0_pc,
    input  wire logic [xlen-1:0]       s0_pc_next,
    input  wire logic [exp_w-1:0]      s0_exp,
    input  wire logic [xlen-1:0]       s0_imm,

    input  wire logic                  s1_en,
    input  wire uop_t                  s1_uop,
    input  wire logic [reg_addr_w-1:0] s1_rd,
    input  wire logic [reg_addr_w-1:0] s1_rj,
    input  wire logic [reg_addr_w-1:0] s1_rk,
    input  wire logic [xlen-1:0]       s1_pc,
    input  wire logic [xlen-1:0]       s1_pc_next,
    input  wire logic [exp_w-1:0]      s1_exp,
    input  wire logic [xlen-1:0]       s1_imm,

    output logic                       ex0_en,
    output uop_t                       ex0_uop,
    output logic      [reg_addr_w-1:0] ex0_rd,
    output logic      [reg_addr_w-1:0] ex0_rj,
    output logic      [reg_addr_w-1:0] ex0_rk,
    output logic      [xlen-1:0]       ex0_pc,
    output logic      [xlen-1:0]       ex0_pc_next,
    output logic      [exp_w-1:0]      ex0_exp,
    output logic      [xlen-1:0]       ex0_imm,
    output logic      [xlen-1:0]       ex0_src1,
    output logic      [xlen-1:0]       ex0_src2,

    output logic                       ex1_en,
    output uop_t                       ex1_uop,
    output logic      [reg_addr_w-1:0] ex1_rd,
    output logic      [reg_addr_w-1:0] ex1_rj,
    output logic      [reg_addr_w-1:0] ex1_rk,
    output logic      [xlen-1:0]       ex1_pc,
    output logic      [xlen-1:0]       ex1_pc_next,
    output logic      [exp_w-1:0]      ex1_exp,
    output logic      [xlen-1:0]       ex1_imm,
    output logic      [xlen-1:0]       ex1_src1,
    output logic      [xlen-1:0]       ex1_src2
);

    logic [63:0] count;

    issue_slot_if slot0 ();
    issue_slot_if slot1 ();

    assign slot0.en      = s0_en;
    assign slot0.uop     = s0_uop;
    assign slot0.rd      = s0_rd;
    assign slot0.rj      = s0_rj;
    assign slot0.rk      = s0_rk;
    assign slot0.pc      = s0_pc;
    assign slot0.pc_next = s0_pc_next;
    assign slot0.exp     = s0_exp;
    assign slot0.imm     = s0_imm;

    assign slot1.en      = s1_en;
    assign slot1.uop     = s1_uop;
    assign slot1.rd      = s1_rd;
    assign slot1.rj      = s1_rj;
    assign slot1.rk      = s1_rk;
    assign slot1.pc      = s1_pc;
    assign slot1.pc_next = s1_pc_next;
    assign slot1.exp     = s1_exp;
    assign slot1.imm     = s1_imm;

    stable_counter i_stable_counter (
        .clk   (clk),
        .rstn  (rstn),
        .count (count)
    );

    rf_stage i_rf_stage (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .slot0       (slot0.stage),
        .slot1       (slot1.stage),
        .count       (count),
        .wb0_en      (wb0_en),
        .wb0_addr    (wb0_addr),
        .wb0_data    (wb0_data),
        .wb1_en      (wb1_en),
        .wb1_addr    (wb1_addr),
        .wb1_data    (wb1_data),
        .ex0_en      (ex0_en),
        .ex0_uop     (ex0_uop),
        .ex0_rd      (ex0_rd),
        .ex0_rj      (ex0_rj),
        .ex0_rk      (ex0_rk),
        .ex0_pc      (ex0_pc),
        .ex0_pc_next (ex0_pc_next),
        .ex0_exp     (ex0_exp),
        .ex0_imm     (ex0_imm),
        .ex0_src1    (ex0_src1),
        .ex0_src2    (ex0_src2),
        .ex1_en      (ex1_en),
        .ex1_uop     (ex1_uop),
        .ex1_rd      (ex1_rd),
        .ex1_rj      (ex1_rj),
        .ex1_rk      (ex1_rk),
        .ex1_pc      (ex1_pc),
        .ex1_pc_next (ex1_pc_next),
        .ex1_exp     (ex1_exp),
        .ex1_imm     (ex1_imm),
        .ex1_src1    (ex1_src1),
        .ex1_src2    (ex1_src2)
    );

endmodule

`default_nettype wire

//--- design/rf_stage.sv
// register-read stage: reads operands for both issue slots and registers them toward execute
`timescale 1ns/10ps
`default_nettype none

module rf_stage
    import rf_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  stall,

    issue_slot_if.stage                slot0,
    issue_slot_if.stage                slot1,
    input  wire logic [63:0]           count,

    input  wire logic                  wb0_en,
    input  wire logic [reg_addr_w-1:0] wb0_addr,
    input  wire logic [xlen-1:0]       wb0_data,
    input  wire logic                  wb1_en,
    input  wire logic [reg_addr_w-1:0] wb1_addr,
    input  wire logic [xlen-1:0]       wb1_data,

    output logic                       ex0_en,
    output uop_t                       ex0_uop,
    output logic      [reg_addr_w-1:0] ex0_rd,
    output logic      [reg_addr_w-1:0] ex0_rj,
    output logic      [reg_addr_w-1:0] ex0_rk,
    output logic      [xlen-1:0]       ex0_pc,
    output logic      [xlen-1:0]       ex0_pc_next,
    output logic      [exp_w-1:0]      ex0_exp,
    output logic      [xlen-1:0]       ex0_imm,
    output logic      [xlen-1:0]       ex0_src1,
    output logic      [xlen-1:0]       ex0_src2,

    output logic                       ex1_en,
    output uop_t                       ex1_uop,
    output logic      [reg_addr_w-1:0] ex1_rd,
    output logic      [reg_addr_w-1:0] ex1_rj,
    output logic      [reg_addr_w-1:0] ex1_rk,
    output logic      [xlen-1:0]       ex1_pc,
    output logic      [xlen-1:0]       ex1_pc_next,
    output logic      [exp_w-1:0]      ex1_exp,
    output logic      [xlen-1:0]       ex1_imm,
    output logic      [xlen-1:0]       ex1_src1,
    output logic      [xlen-1:0]       ex1_src2
);

    logic [3:0][reg_addr_w-1:0] raddr;
    logic [3:0][xlen-1:0]       rdata;
    logic [xlen-1:0]            sel0_a;
    logic [xlen-1:0]            sel0_b;
    logic [xlen-1:0]            sel1_a;
    logic [xlen-1:0]            sel1_b;

    // read ports 0/1 serve slot 0, ports 2/3 serve slot 1
    assign raddr[0] = slot0.rj;
    assign raddr[1] = slot0.rk;
    assign raddr[2] = slot1.rj;
    assign raddr[3] = slot1.rk;

    reg_array i_reg_array (
        .clk      (clk),
        .wb0_en   (wb0_en),
        .wb0_addr (wb0_addr),
        .wb0_data (wb0_data),
        .wb1_en   (wb1_en),
        .wb1_addr (wb1_addr),
        .wb1_data (wb1_data),
        .raddr    (raddr),
        .rdata    (rdata)
    );

    operand_select i_opsel0 (
        .uop   (slot0.uop),
        .rf_a  (rdata[0]),
        .rf_b  (rdata[1]),
        .pc    (slot0.pc),
        .imm   (slot0.imm),
        .count (count),
        .src_a (sel0_a),
        .src_b (sel0_b)
    );

    operand_select i_opsel1 (
        .uop   (slot1.uop),
        .rf_a  (rdata[2]),
        .rf_b  (rdata[3]),
        .pc    (slot1.pc),
        .imm   (slot1.imm),
        .count (count),
        .src_a (sel1_a),
        .src_b (sel1_b)
    );

    // stall holds every output, writeback is not affected
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex0_en      <= 1'b0;
            ex0_uop     <= '0;
            ex0_rd      <= '0;
            ex0_rj      <= '0;
            ex0_rk      <= '0;
            ex0_pc      <= '0;
            ex0_pc_next <= '0;
            ex0_exp     <= '0;
            ex0_imm     <= '0;
            ex0_src1    <= '0;
            ex0_src2    <= '0;
            ex1_en      <= 1'b0;
            ex1_uop     <= '0;
            ex1_rd      <= '0;
            ex1_rj      <= '0;
            ex1_rk      <= '0;
            ex1_pc      <= '0;
            ex1_pc_next <= '0;
            ex1_exp     <= '0;
            ex1_imm     <= '0;
            ex1_src1    <= '0;
            ex1_src2    <= '0;
        end else if (!stall) begin
            ex0_en      <= slot0.en;
            ex0_uop     <= slot0.uop;
            ex0_rd      <= slot0.rd;
            ex0_rj      <= slot0.rj;
            ex0_rk      <= slot0.rk;
            ex0_pc      <= slot0.pc;
            ex0_pc_next <= slot0.pc_next;
            ex0_exp     <= slot0.exp;
            ex0_imm     <= slot0.imm;
            ex0_src1    <= sel0_a;
            ex0_src2    <= sel0_b;
            ex1_en      <= slot1.en;
            ex1_uop     <= slot1.uop;
            ex1_rd      <= slot1.rd;
            ex1_rj      <= slot1.rj;
            ex1_rk      <= slot1.rk;
            ex1_pc      <= slot1.pc;
            ex1_pc_next <= slot1.pc_next;
            ex1_exp     <= slot1.exp;
            ex1_imm     <= slot1.imm;
            ex1_src1    <= sel1_a;
            ex1_src2    <= sel1_b;
        end
    end

endmodule

`default_nettype wire

//--- design/stable_counter.sv
// stable counter: free-running 64-bit timer readable as an alu operand
`timescale 1ns/10ps
`default_nettype none

module stable_counter (
    input  wire logic        clk,
    input  wire logic        rstn,
    output logic      [63:0] count
);

    // keeps running through stalls
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            count <= count + 64'd1;
        end
    end

endmodule

`default_nettype wire

//--- rf_read_top.f
design/rf_pkg.sv
design/issue_slot_if.sv
design/reg_array.sv
design/operand_select.sv
design/stable_counter.sv
design/rf_stage.sv
design/rf_read_top.sv
verification/tb_rf_read_top.sv

//--- verification/tb_rf_read_top.sv
// register-read stage testbench: random issue and writeback traffic checked against a reference model
`timescale 1ns/10ps
`default_nettype none

module tb_rf_read_top
    import rf_pkg::*;
();

    localparam int clk_period  = 20;
    localparam int stim_cycles = 200;

    typedef struct packed {
        logic                  en;
        uop_t                  uop;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rk;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       pc_next;
        logic [exp_w-1:0]      exp;
        logic [xlen-1:0]       imm;
    } slot_in_t;

    typedef struct packed {
        slot_in_t        f;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
    } ex_out_t;

    logic                  clk;
    logic                  rstn;
    logic                  stall;
    logic                  wb0_en, wb1_en;
    logic [reg_addr_w-1:0] wb0_addr, wb1_addr;
    logic [xlen-1:0]       wb0_data, wb1_data;
    slot_in_t              slot_in [2];

    logic                  ex0_en, ex1_en;
    uop_t                  ex0_uop, ex1_uop;
    logic [reg_addr_w-1:0] ex0_rd, ex0_rj, ex0_rk, ex1_rd, ex1_rj, ex1_rk;
    logic [xlen-1:0]       ex0_pc, ex0_pc_next, ex0_imm, ex0_src1, ex0_src2;
    logic [xlen-1:0]       ex1_pc, ex1_pc_next, ex1_imm, ex1_src1, ex1_src2;
    logic [exp_w-1:0]      ex0_exp, ex1_exp;

    integer                seed = 60251;
    string                 test_name;
    string                 exp_test;
    logic [xlen-1:0]       model_regs [reg_count];
    logic [63:0]           model_cnt;
    ex_out_t               exp_out [2];
    ex_out_t               act0;
    ex_out_t               act1;
    logic [2*$bits(ex_out_t)-1:0] ex_all;
    logic                  check_valid;

    rf_read_top i_rf_read_top (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .wb0_en      (wb0_en),
        .wb0_addr    (wb0_addr),
        .wb0_data    (wb0_data),
        .wb1_en      (wb1_en),
        .wb1_addr    (wb1_addr),
        .wb1_data    (wb1_data),
        .s0_en       (slot_in[0].en),
        .s0_uop      (slot_in[0].uop),
        .s0_rd       (slot_in[0].rd),
        .s0_rj       (slot_in[0].rj),
        .s0_rk       (slot_in[0].rk),
        .s0_pc       (slot_in[0].pc),
        .s0_pc_next  (slot_in[0].pc_next),
        .s0_exp      (slot_in[0].exp),
        .s0_imm      (slot_in[0].imm),
        .s1_en       (slot_in[1].en),
        .s1_uop      (slot_in[1].uop),
        .s1_rd       (slot_in[1].rd),
        .s1_rj       (slot_in[1].rj),
        .s1_rk       (slot_in[1].rk),
        .s1_pc       (slot_in[1].pc),
        .s1_pc_next  (slot_in[1].pc_next),
        .s1_exp      (slot_in[1].exp),
        .s1_imm      (slot_in[1].imm),
        .ex0_en      (ex0_en),
        .ex0_uop     (ex0_uop),
        .ex0_rd      (ex0_rd),
        .ex0_rj      (ex0_rj),
        .ex0_rk      (ex0_rk),
        .ex0_pc      (ex0_pc),
        .ex0_pc_next (ex0_pc_next),
        .ex0_exp     (ex0_exp),
        .ex0_imm     (ex0_imm),
        .ex0_src1    (ex0_src1),
        .ex0_src2    (ex0_src2),
        .ex1_en      (ex1_en),
        .ex1_uop     (ex1_uop),
        .ex1_rd      (ex1_rd),
        .ex1_rj      (ex1_rj),
        .ex1_rk      (ex1_rk),
        .ex1_pc      (ex1_pc),
        .ex1_pc_next (ex1_pc_next),
        .ex1_exp     (ex1_exp),
        .ex1_imm     (ex1_imm),
        .ex1_src1    (ex1_src1),
        .ex1_src2    (ex1_src2)
    );

    assign act0 = {ex0_en, ex0_uop, ex0_rd, ex0_rj, ex0_rk, ex0_pc, ex0_pc_next,
                   ex0_exp, ex0_imm, ex0_src1, ex0_src2};
    assign act1 = {ex1_en, ex1_uop, ex1_rd, ex1_rj, ex1_rk, ex1_pc, ex1_pc_next,
                   ex1_exp, ex1_imm, ex1_src1, ex1_src2};
    assign ex_all = {act0, act1};

    always #(clk_period / 2) clk = ~clk;

    // register read as seen in the cycle of a write, port 1 is younger
    function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb1_en && wb1_addr == addr) begin
            return wb1_data;
        end
        if (wb0_en && wb0_addr == addr) begin
            return wb0_data;
        end
        return model_regs[addr];
    endfunction

    function automatic ex_out_t predict_slot(input slot_in_t s, input logic [63:0] cnt);
        ex_out_t o;
        o.f    = s;
        o.src1 = read_reg(s.rj);
        o.src2 = read_reg(s.rk);
        if (s.uop.itype == itype_alu) begin
            case (s.uop.src1)
                src1_pc:    o.src1 = s.pc;
                src1_zero:  o.src1 = '0;
                src1_cntid: o.src1 = '0;
                default:    ;
            endcase
            case (s.uop.src2)
                src2_imm:  o.src2 = s.imm;
                src2_cntl: o.src2 = cnt[31:0];
                src2_cnth: o.src2 = cnt[63:32];
                default:   ;
            endcase
        end
        return o;
    endfunction

    // reference model, expectations are checked at the following falling edge
    always @(posedge clk) begin
        if (!rstn) begin
            exp_out[0] = '0;
            exp_out[1] = '0;
        end else if (!stall) begin
            exp_out[0] = predict_slot(slot_in[0], model_cnt);
            exp_out[1] = predict_slot(slot_in[1], model_cnt);
        end
        exp_test = test_name;
        if (wb0_en && wb0_addr != '0) begin
            model_regs[wb0_addr] = wb0_data;
        end
        if (wb1_en && wb1_addr != '0) begin
            model_regs[wb1_addr] = wb1_data;
        end
        model_cnt   = rstn ? model_cnt + 64'd1 : 64'd0;
        check_valid = 1'b1;
    end

    task automatic check_field(input int idx, input string field,
                               input logic [31:0] expv, input logic [31:0] actv);
        assert (actv === expv) else begin
            $display("ERROR %s slot %0d %s: expected %h, actual %h",
                     exp_test, idx, field, expv, actv);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_slot(input int idx, input ex_out_t e, input ex_out_t a);
        check_field(idx, "en", 32'(e.f.en), 32'(a.f.en));
        check_field(idx, "uop", 32'(e.f.uop), 32'(a.f.uop));
        check_field(idx, "rd", 32'(e.f.rd), 32'(a.f.rd));
        check_field(idx, "rj", 32'(e.f.rj), 32'(a.f.rj));
        check_field(idx, "rk", 32'(e.f.rk), 32'(a.f.rk));
        check_field(idx, "pc", e.f.pc, a.f.pc);
        check_field(idx, "pc_next", e.f.pc_next, a.f.pc_next);
        check_field(idx, "exp", 32'(e.f.exp), 32'(a.f.exp));
        check_field(idx, "imm", e.f.imm, a.f.imm);
        check_field(idx, "src1", e.src1, a.src1);
        check_field(idx, "src2", e.src2, a.src2);
    endtask

    always @(negedge clk) begin
        if (check_valid) begin
            check_slot(0, exp_out[0], act0);
            check_slot(1, exp_out[1], act1);
        end
    end

    // a stalled edge must leave every ex output untouched
    stall_hold: assert property (@(posedge clk) (rstn && stall) |=> $stable(ex_all))
        else begin
            $display("ex outputs changed at an edge where stall was high");
            $display("sim failed");
            $fatal(1);
        end

    reset_clear: assert property (@(posedge clk) !rstn |=> (ex_all == '0))
        else begin
            $display("ex outputs were not cleared by reset");
            $display("sim failed");
            $fatal(1);
        end

    task automatic set_writes(input logic en0, input logic [reg_addr_w-1:0] a0,
                              input logic [xlen-1:0] d0, input logic en1,
                              input logic [reg_addr_w-1:0] a1, input logic [xlen-1:0] d1);
        wb0_en   <= en0;
        wb0_addr <= a0;
        wb0_data <= d0;
        wb1_en   <= en1;
        wb1_addr <= a1;
        wb1_data <= d1;
    endtask

    task automatic random_writes();
        logic [31:0] r;
        logic [31:0] d0;
        logic [31:0] d1;
        r  = $random(seed);
        d0 = $random(seed);
        d1 = $random(seed);
        set_writes(r[0], r[5:1], d0, r[6], r[11:7], d1);
    endtask

    // remaining slot fields are random
    task automatic set_slot(input int idx, input itype_e it, input src1_e s1, input src2_e s2,
                            input logic [reg_addr_w-1:0] rj, input logic [reg_addr_w-1:0] rk);
        slot_in_t     s;
        logic [127:0] r;
        r = {$random(seed), $random(seed), $random(seed), $random(seed)};
        s.en        = r[0];
        s.uop.itype = it;
        s.uop.src1  = s1;
        s.uop.src2  = s2;
        s.uop.op    = r[8:1];
        s.rd        = r[13:9];
        s.rj        = rj;
        s.rk        = rk;
        s.exp       = r[20:14];
        s.pc        = r[63:32];
        s.pc_next   = r[95:64];
        s.imm       = r[127:96];
        slot_in[idx] <= s;
    endtask

    task automatic random_slot(input int idx, input bit alu_allowed);
        logic [31:0] r;
        itype_e      it;
        r = $random(seed);
        if (alu_allowed || r[1:0] != 2'd0) begin
            it = itype_e'({1'b0, r[1:0]});
        end else begin
            it = itype_misc;
        end
        set_slot(idx, it, src1_e'(r[3:2]), src2_e'(r[5:4]), r[10:6], r[15:11]);
    endtask

    initial begin
        logic [31:0]           r;
        logic [31:0]           d0;
        logic [31:0]           d1;
        logic [reg_addr_w-1:0] a;
        int                    i;
        int                    j;
        clk         = 1'b0;
        rstn        = 1'b0;
        stall       = 1'b0;
        wb0_en      = 1'b0;
        wb0_addr    = '0;
        wb0_data    = '0;
        wb1_en      = 1'b0;
        wb1_addr    = '0;
        wb1_data    = '0;
        slot_in[0]  = '0;
        slot_in[1]  = '0;
        model_cnt   = '0;
        check_valid = 1'b0;
        test_name   = "reset";

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        // one idle edge after reset, outputs must stay zero
        @(posedge clk);

        test_name <= "register read";
        for (i = 1; i < reg_count; i += 2) begin
            @(posedge clk);
            d0 = $random(seed);
            d1 = $random(seed);
            // the last pair also writes r0
            set_writes(1'b1, 5'(i), d0, 1'b1, 5'((i + 1) % reg_count), d1);
            set_slot(0, itype_mem, src1_rf, src2_rf, '0, '0);
            set_slot(1, itype_br, src1_rf, src2_rf, '0, '0);
        end
        @(posedge clk);
        d0 = $random(seed);
        set_writes(1'b1, '0, d0, 1'b0, '0, '0);
        set_slot(0, itype_misc, src1_pc, src2_imm, '0, '0);
        set_slot(1, itype_mem, src1_rf, src2_rf, '0, 5'd1);
        @(posedge clk);
        set_writes(1'b0, '0, '0, 1'b0, '0, '0);
        set_slot(0, itype_br, src1_zero, src2_cnth, '0, '0);
        set_slot(1, itype_alu, src1_rf, src2_rf, '0, '0);
        for (i = 0; i < 40; i++) begin
            @(posedge clk);
            random_writes();
            random_slot(0, 1'b0);
            random_slot(1, 1'b0);
        end

        test_name <= "forwarding";
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            r  = $random(seed);
            a  = (r[4:0] == '0) ? 5'd1 : r[4:0];
            d0 = $random(seed);
            set_writes(1'b1, a, d0, 1'b0, '0, '0);
            set_slot(0, itype_mem, src1_rf, src2_rf, a, r[9:5]);
            set_slot(1, itype_alu, src1_rf, src2_rf, r[14:10], a);
            @(posedge clk);
            d0 = $random(seed);
            d1 = $random(seed);
            set_writes(1'b1, a, d0, 1'b1, a, d1);
            set_slot(0, itype_br, src1_rf, src2_rf, r[9:5], a);
            set_slot(1, itype_mem, src1_rf, src2_rf, a, a);
            // read back after the clash
            @(posedge clk);
            set_writes(1'b0, '0, '0, 1'b0, '0, '0);
            set_slot(0, itype_misc, src1_rf, src2_rf, a, a);
            set_slot(1, itype_alu, src1_rf, src2_rf, a, r[14:10]);
        end

        test_name <= "operand sources";
        for (i = 0; i < 4; i++) begin
            for (j = 0; j < 4; j++) begin
                @(posedge clk);
                random_writes();
                r = $random(seed);
                set_slot(0, itype_alu, src1_e'(i[1:0]), src2_e'(j[1:0]), r[4:0], r[9:5]);
                set_slot(1, itype_alu, src1_e'(j[1:0]), src2_e'(i[1:0]), r[14:10], r[19:15]);
            end
        end
        for (i = 0; i < 24; i++) begin
            @(posedge clk);
            random_writes();
            random_slot(0, 1'b1);
            random_slot(1, 1'b1);
        end

        test_name <= "stall";
        for (i = 0; i < 6; i++) begin
            @(posedge clk);
            stall <= 1'b1;
            d0 = $random(seed);
            d1 = $random(seed);
            set_writes(1'b1, 5'(10 + i), d0, 1'b1, 5'(20 + i), d1);
            random_slot(0, 1'b1);
            random_slot(1, 1'b1);
        end
        for (i = 0; i < 6; i++) begin
            @(posedge clk);
            stall <= 1'b0;
            set_writes(1'b0, '0, '0, 1'b0, '0, '0);
            set_slot(0, itype_mem, src1_rf, src2_rf, 5'(10 + i), 5'(20 + i));
            set_slot(1, itype_alu, src1_rf, src2_rf, 5'(20 + i), 5'(10 + i));
        end

        test_name <= "mixed";
        for (i = 0; i < 52; i++) begin
            @(posedge clk);
            r = $random(seed);
            stall <= (r[1:0] == 2'd0);
            random_writes();
            random_slot(0, 1'b1);
            random_slot(1, 1'b1);
        end

        @(posedge clk);
        stall <= 1'b0;
        set_writes(1'b0, '0, '0, 1'b0, '0, '0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        #1;
        $display("sim passed");
        $finish;
    end

    // twice the stimulus length
    initial begin
        #(2 * stim_cycles * clk_period);
        $display("timeout: stimulus did not finish within %0d clock cycles", 2 * stim_cycles);
        $display("sim failed");
        $fatal(1);
    end

endmodule

`default_nettype wire
